// ==== src.f ====
+incdir+logic
logic/cache_pkg.sv
logic/cache_ifs.sv
logic/cache_store.sv
logic/tlb_store.sv
logic/wb_master_port.sv
logic/cache_ctrl.sv
logic/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module cache_tb -Mdir obj_dir -o cache_sim
then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/cache_sim
then
  echo "simulation failed"
  exit 1
fi

exit 0

// ==== sim/cache_tb.sv ====
`default_nettype none

module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 64;

  logic        CPU_CLK = 1'b0;
  logic        RST_CPU;
  logic        en;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        tlb_we;
  logic        vmem_act;
  logic        inhibit;
  logic [31:0] rdata;
  logic        busy;
  logic        done;
  logic        fault;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack;

  integer      seed;
  logic [31:0] wb_mem [logic [31:0]];   // slave memory, written words only
  logic [31:0] ref_mem [logic [31:0]];  // expected memory contents
  logic        slow_ack;
  logic        slave_busy;
  int          ack_wait;

  // result of the last access
  logic [31:0] res_rdata;
  logic        res_fault;
  int          res_lat;  // edge at which done is sampled
  logic        res_cyc;
  logic        res_busy;
  logic [31:0] res_adr;
  logic        res_we;
  logic [31:0] res_dat;

  logic [31:0] addr_a;
  logic [31:0] addr_b;
  logic [31:0] addr_c;
  logic [31:0] addr_e;
  logic [31:0] data_d;
  logic [31:0] rnd_t;
  logic [31:0] rnd_p;

  cache_top UUT (.*);

  always #5 CPU_CLK = ~CPU_CLK;

  // unwritten words, every address bit counts
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    fill_word = {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] pa);
    if (ref_mem.exists(pa) != 0)
      model_read = ref_mem[pa];
    else
      model_read = fill_word(pa);
  endfunction

  // --------------------------------------------------------------------------
  // wishbone slave, random ack delay per cycle
  // --------------------------------------------------------------------------
  always @(posedge CPU_CLK)
  begin
    #1;
    wb_ack = 1'b0;
    if (wb_cyc && wb_stb && !slave_busy)
    begin
      slave_busy = 1'b1;
      ack_wait   = slow_ack ? 4 + ($random(seed) & 7) : ($random(seed) & 3);
    end
    if (slave_busy)
    begin
      if (ack_wait == 0)
      begin
        if (wb_we)
          wb_mem[wb_adr] = wb_dat_o;
        wb_dat_i   = (wb_mem.exists(wb_adr) != 0) ? wb_mem[wb_adr] : fill_word(wb_adr);
        wb_ack     = 1'b1;
        slave_busy = 1'b0;
      end
      else
        ack_wait--;
    end
  end

  task automatic compare_word(input string test, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    assert (act_v === exp_v)
    else
    begin
      $display("MISMATCH %s expected %08h actual %08h", test, exp_v, act_v);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic require_cond(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("ERROR %s", what);
      $display("STATUS: FAIL");
      $fatal(1, "condition check failed");
    end
  endtask

  // one CPU request from acceptance to done
  task automatic run_access(input logic tlb, input logic wr, input logic [31:0] a,
                            input logic [31:0] d, input logic inh, input logic vm,
                            input logic hold);
    int n;
    n = 0;
    @(posedge CPU_CLK);
    #1;
    while (busy)
    begin
      require_cond(n < WAIT_LIMIT, "busy stayed high before a new request");
      @(posedge CPU_CLK);
      #1;
      n++;
    end
    en       = !tlb;
    tlb_we   = tlb;
    we       = wr;
    addr     = a;
    wdata    = d;
    inhibit  = inh;
    vmem_act = vm;
    @(posedge CPU_CLK);  // accepting edge
    #1;
    en       = 1'b0;
    tlb_we   = 1'b0;
    res_cyc  = 1'b0;
    res_busy = 1'b0;
    n        = 0;
    while (!done)
    begin
      require_cond(n < WAIT_LIMIT, "no done after an accepted request");
      @(posedge CPU_CLK);
      #1;
      n++;
      if (wb_cyc)
      begin
        res_cyc = 1'b1;
        res_adr = wb_adr;
        res_we  = wb_we;
        res_dat = wb_dat_o;
        compare_word("bus_sel", 32'h0000_000f, {28'h0, wb_sel});  // whole word lanes
      end
      if (busy)
      begin
        res_busy = 1'b1;
        if (hold)
        begin
          en    = 1'b1;  // competing write, must be ignored
          we    = 1'b1;
          addr  = ~a;
          wdata = ~d;
        end
      end
      else if (res_busy && !done)
        require_cond(1'b0, "busy fell before done");
    end
    en        = 1'b0;
    we        = 1'b0;
    res_lat   = n + 1;
    res_rdata = rdata;
    res_fault = fault;
  endtask

  initial
  begin
    seed       = 32'h528d9cd2;
    RST_CPU    = 1'b1;
    en         = 1'b0;
    we         = 1'b0;
    addr       = 32'd0;
    wdata      = 32'd0;
    tlb_we     = 1'b0;
    vmem_act   = 1'b0;
    inhibit    = 1'b0;
    wb_ack     = 1'b0;
    wb_dat_i   = 32'd0;
    slow_ack   = 1'b0;
    slave_busy = 1'b0;
    ack_wait   = 0;
    addr_a     = $random(seed);
    data_d     = $random(seed);
    rnd_t      = $random(seed);
    rnd_p      = $random(seed);
    addr_b     = addr_a ^ 32'h0000_0001;  // other line
    addr_c     = addr_a ^ 32'h0001_0000;  // same line, other tag
    addr_e     = addr_a ^ 32'h0100_0000;
    repeat (4) @(posedge CPU_CLK);
    #1;
    RST_CPU = 1'b0;
    require_cond(!busy && !done && !fault && !wb_cyc && !wb_stb && !wb_we,
                 "outputs not idle after reset");

    // --------------------------------------------------------------------------
    // miss, hit, write-through, inhibit
    // --------------------------------------------------------------------------
    run_access(1'b0, 1'b0, addr_a, 32'd0, 1'b0, 1'b0, 1'b0);
    require_cond(res_cyc && !res_we, "read miss made no bus read");
    compare_word("miss_addr", addr_a, res_adr);
    compare_word("miss_read", model_read(addr_a), res_rdata);
    run_access(1'b0, 1'b0, addr_a, 32'd0, 1'b0, 1'b0, 1'b0);
    require_cond(!res_cyc && !res_busy, "read hit used the bus");
    compare_word("hit_latency", 32'd2, 32'(res_lat));
    compare_word("hit_read", model_read(addr_a), res_rdata);

    run_access(1'b0, 1'b1, addr_b, data_d, 1'b0, 1'b0, 1'b0);
    ref_mem[addr_b] = data_d;
    require_cond(res_cyc && res_we, "write made no bus write");
    compare_word("write_addr", addr_b, res_adr);
    compare_word("write_data", data_d, res_dat);
    run_access(1'b0, 1'b0, addr_b, 32'd0, 1'b0, 1'b0, 1'b0);
    require_cond(!res_cyc, "read after write missed the cache");
    compare_word("write_hit", data_d, res_rdata);

    run_access(1'b0, 1'b0, addr_a, 32'd0, 1'b1, 1'b0, 1'b0);
    require_cond(res_cyc, "inhibited read of a cached line skipped the bus");
    compare_word("inhibit_read", model_read(addr_a), res_rdata);
    run_access(1'b0, 1'b1, addr_c, ~data_d, 1'b1, 1'b0, 1'b0);
    ref_mem[addr_c] = ~data_d;
    require_cond(res_cyc && res_we, "inhibited write made no bus write");
    run_access(1'b0, 1'b0, addr_c, 32'd0, 1'b1, 1'b0, 1'b0);
    require_cond(res_cyc, "inhibited read skipped the bus");
    compare_word("inhibit_reread", ~data_d, res_rdata);

    // line of addr_a shares its index with addr_c and must still hold addr_a
    run_access(1'b0, 1'b0, addr_a, 32'd0, 1'b0, 1'b0, 1'b0);
    require_cond(!res_cyc, "inhibited access replaced a cached line");
    compare_word("inhibit_kept", model_read(addr_a), res_rdata);

    // --------------------------------------------------------------------------
    // translation and fault
    // --------------------------------------------------------------------------
    run_access(1'b1, 1'b0, {16'h0, rnd_t[15:8], 8'h00}, {rnd_p[15:0], rnd_t[31:16]},
               1'b0, 1'b0, 1'b0);
    compare_word("tlb_latency", 32'd1, 32'(res_lat));
    run_access(1'b0, 1'b0, rnd_t, 32'd0, 1'b0, 1'b1, 1'b0);
    require_cond(res_cyc && !res_fault, "translated read made no bus read");
    compare_word("tlb_page", {16'h0, rnd_p[15:0]}, {16'h0, res_adr[31:16]});
    compare_word("tlb_read", model_read({rnd_p[15:0], rnd_t[15:0]}), res_rdata);

    run_access(1'b0, 1'b0, {~rnd_t[31:16], rnd_t[15:0]}, 32'd0, 1'b0, 1'b1, 1'b0);
    require_cond(res_fault && !res_cyc, "page mismatch did not fault without a bus cycle");
    compare_word("fault_latency", 32'd2, 32'(res_lat));

    // slow slave, a second request held while busy
    slow_ack = 1'b1;
    run_access(1'b0, 1'b0, addr_e, 32'd0, 1'b0, 1'b0, 1'b1);
    require_cond(res_busy, "slow miss never raised busy");
    compare_word("slow_read", model_read(addr_e), res_rdata);
    repeat (5)
    begin
      @(posedge CPU_CLK);
      #1;
      require_cond(!done && !wb_cyc, "request presented while busy was taken");
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/cache_sva.sv ====
`default_nettype none

module cache_sva (
  input logic        CPU_CLK,
  input logic        RST_CPU,
  input logic        cyc,
  input logic        stb,
  input logic        we,
  input logic [31:0] adr,
  input logic [31:0] dat_o,
  input logic        ack,
  input logic        done,
  input logic        fault,
  input logic        bus_req
);
  timeunit 1ns;
  timeprecision 1ps;

  stb_in_cyc: assert property (@(posedge CPU_CLK) disable iff (RST_CPU) stb |-> cyc)
    else $error("wb_stb high outside wb_cyc");

  // classic cycle holds its request until ack
  bus_held: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    (cyc && stb && !ack) |=> (cyc && stb && $stable(adr) && $stable(dat_o) && $stable(we)))
    else $error("wishbone request changed before ack");

  done_pulse: assert property (@(posedge CPU_CLK) disable iff (RST_CPU) done |=> !done)
    else $error("done high for more than one cycle");

  fault_no_bus: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    fault |-> !$past(bus_req))
    else $error("faulting request started a bus cycle");

endmodule

// --------------------------------------------------------------------------
// wishbone side of the master port
// --------------------------------------------------------------------------
bind wb_master_port cache_sva u_sva (
  .CPU_CLK(CPU_CLK), .RST_CPU(RST_CPU), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
  .adr(wb_adr), .dat_o(wb_dat_o), .ack(wb_ack), .done(1'b0), .fault(1'b0),
  .bus_req(1'b0)
);

// completion side of the controller
bind cache_ctrl cache_sva u_sva (
  .CPU_CLK(CPU_CLK), .RST_CPU(RST_CPU), .cyc(1'b0), .stb(1'b0), .we(1'b0),
  .adr(32'd0), .dat_o(32'd0), .ack(1'b0), .done(done), .fault(fault),
  .bus_req(use_bus)
);

`default_nettype wire

// ==== logic/cache_top.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_top
  import cache_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST_CPU,
  input  logic        en,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic        tlb_we,
  input  logic        vmem_act,
  input  logic        inhibit,
  output logic [31:0] rdata,
  output logic        busy,
  output logic        done,
  output logic        fault,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [3:0]  wb_sel,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_dat_o,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack
);

  line_wr_if line_wr ();
  bus_req_if bus_req ();

  logic                    hit;
  logic [31:0]             line_data;
  logic [`PAGE_W-1:0]      phys_page;
  logic                    tlb_fault;
  logic                    lookup_en;
  cpu_addr_u               lookup_addr;
  logic [`CACHE_TAG_W-1:0] lookup_tag;

  cache_ctrl u_ctrl (
    .CPU_CLK, .RST_CPU, .en, .we, .addr, .wdata, .tlb_we, .vmem_act, .inhibit,
    .rdata, .busy, .done, .fault, .hit, .line_data, .phys_page,
    .fault_in(tlb_fault), .lookup_en, .lookup_addr, .lookup_tag,
    .line(line_wr.driver), .bus(bus_req.requester)
  );

  cache_store u_store (
    .CPU_CLK, .RST_CPU, .rd_en(lookup_en), .rd_idx(lookup_addr.c.idx),
    .rd_tag(lookup_tag), .hit, .rd_data(line_data), .wr(line_wr.target)
  );

  // translation entry select comes from the same address bits as a lookup
  tlb_store u_tlb (
    .CPU_CLK, .RST_CPU, .rd_en(lookup_en), .rd_addr(lookup_addr), .vmem_act,
    .wr_en(tlb_we && !busy), .wr_idx(addr[15:8]), .wr_entry(wdata),
    .phys_page, .fault(tlb_fault)
  );

  wb_master_port u_wb (
    .CPU_CLK, .RST_CPU, .req(bus_req.port), .wb_cyc, .wb_stb, .wb_we, .wb_sel,
    .wb_adr, .wb_dat_o, .wb_dat_i, .wb_ack
  );

endmodule

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic                    CPU_CLK,
  input  logic                    RST_CPU,
  input  logic                    en,
  input  logic                    we,
  input  logic [31:0]             addr,
  input  logic [31:0]             wdata,
  input  logic                    tlb_we,
  input  logic                    vmem_act,
  input  logic                    inhibit,
  output logic [31:0]             rdata,
  output logic                    busy,
  output logic                    done,
  output logic                    fault,
  input  logic                    hit,
  input  logic [31:0]             line_data,
  input  logic [`PAGE_W-1:0]      phys_page,
  input  logic                    fault_in,
  output logic                    lookup_en,
  output cpu_addr_u               lookup_addr,
  output logic [`CACHE_TAG_W-1:0] lookup_tag,
  line_wr_if.driver               line,
  bus_req_if.requester            bus
);

  ctrl_state_e             state;
  cpu_addr_u               req_addr;
  logic [31:0]             req_wdata;
  logic                    req_we;
  logic                    req_inh;
  logic                    req_vmem;
  logic [`CACHE_IDX_W-1:0] fill_idx;
  logic [`CACHE_TAG_W-1:0] fill_tag;
  logic [31:0]             fill_wdata;
  logic                    fill_we;
  logic                    fill_inh;
  logic [31:0]             rdata_q;
  logic                    done_q;
  logic                    fault_q;
  logic                    take_req;
  logic                    take_tlb;
  logic                    req_fault;
  logic                    use_bus;

  // ---------------------------------------------------------------------------
  // acceptance and lookup decision
  // ---------------------------------------------------------------------------
  assign busy = ((state == BUS) && !bus.done) || (state == FILL) || (state == DONE);

  assign take_tlb = tlb_we && !busy;
  assign take_req = en && !tlb_we && !busy;  // translation write wins

  // a fault only counts for a request issued with translation on
  assign req_fault = fault_in && req_vmem;
  assign use_bus   = (state == LOOKUP) && !req_fault && (req_we || req_inh || !hit);

  // parked request reads the arrays again once the fill is in
  assign lookup_en   = take_req || (state == DONE);
  assign lookup_addr = (state == DONE) ? req_addr : cpu_addr_u'(addr);
  assign lookup_tag  = {phys_page, req_addr.t.tidx};

  assign bus.req   = use_bus;
  assign bus.we    = req_we;
  assign bus.addr  = {phys_page, req_addr.t.tidx, req_addr.t.lidx};
  assign bus.wdata = req_wdata;

  // line update on completion of a non inhibited bus access
  assign line.we   = bus.done && !fill_inh;
  assign line.idx  = fill_idx;
  assign line.tag  = fill_tag;
  assign line.data = fill_we ? fill_wdata : bus.rdata;

  assign done  = done_q || bus.done;
  assign rdata = bus.done ? bus.rdata : rdata_q;
  assign fault = fault_q;

  // ---------------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state   <= IDLE;
      done_q  <= 1'b0;
      fault_q <= 1'b0;
    end
    else
    begin
      done_q  <= take_tlb;
      fault_q <= 1'b0;
      case (state)
        IDLE:
          state <= take_req ? LOOKUP : IDLE;
        LOOKUP:
        begin
          if (use_bus)
            state <= take_req ? FILL : BUS;  // a new request waits for the fill
          else
          begin
            done_q  <= 1'b1;  // hit or fault
            fault_q <= req_fault;
            state   <= take_req ? LOOKUP : IDLE;
          end
        end
        BUS:
          if (bus.done)
            state <= take_req ? LOOKUP : IDLE;
        FILL:
          if (bus.done)
            state <= DONE;
        DONE:
          state <= LOOKUP;
        default:
          state <= IDLE;
      endcase
    end
  end

  // request and fill payload
  always_ff @(posedge CPU_CLK)
  begin
    if (take_req)
    begin
      req_addr  <= addr;
      req_we    <= we;
      req_wdata <= wdata;
      req_inh   <= inhibit;
      req_vmem  <= vmem_act;
    end
    if ((state == LOOKUP) && !use_bus)
      rdata_q <= line_data;
    if (use_bus)
    begin
      fill_idx   <= req_addr.c.idx;
      fill_tag   <= lookup_tag;
      fill_wdata <= req_wdata;
      fill_we    <= req_we;
      fill_inh   <= req_inh;
    end
  end

endmodule

`default_nettype wire

// ==== logic/wb_master_port.sv ====
`default_nettype none

module wb_master_port (
  input  logic        CPU_CLK,
  input  logic        RST_CPU,
  bus_req_if.port     req,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [3:0]  wb_sel,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_dat_o,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack
);

  logic cyc_q;  // high while a cycle is in flight
  logic start;
  logic finish;

  assign start  = req.req && !cyc_q;
  assign finish = cyc_q && wb_ack;

  // ---------------------------------------------------------------------------
  // cycle control
  // ---------------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      cyc_q    <= 1'b0;
      wb_we    <= 1'b0;
      req.done <= 1'b0;
    end
    else
    begin
      req.done <= finish;
      if (start)
      begin
        cyc_q <= 1'b1;
        wb_we <= req.we;
      end
      else if (finish)
      begin
        cyc_q <= 1'b0;
        wb_we <= 1'b0;
      end
    end
  end

  // address and data held from request until ack
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      wb_adr   <= req.addr;
      wb_dat_o <= req.wdata;
    end
    if (finish)
      req.rdata <= wb_dat_i;  // returned with done
  end

  assign wb_cyc = cyc_q;
  assign wb_stb = cyc_q;
  assign wb_sel = 4'b1111;  // whole words only

endmodule

`default_nettype wire

// ==== logic/tlb_store.sv ====
`default_nettype none

`include "cache_consts.svh"

module tlb_store
  import cache_pkg::*;
(
  input  logic                    CPU_CLK,
  input  logic                    RST_CPU,
  input  logic                    rd_en,
  input  cpu_addr_u               rd_addr,
  input  logic                    vmem_act,
  input  logic                    wr_en,
  input  logic [`CACHE_IDX_W-1:0] wr_idx,
  input  logic [31:0]             wr_entry,  // physical page high, virtual tag low
  output logic [`PAGE_W-1:0]      phys_page,
  output logic                    fault
);

  logic [`PAGE_W-1:0] page_mem [`CACHE_LINES];
  logic [`PAGE_W-1:0] vtag_mem [`CACHE_LINES];
  logic [`PAGE_W-1:0] page_q;
  logic [`PAGE_W-1:0] vtag_q;
  logic [`PAGE_W-1:0] req_page_q;  // page of the request being translated
  logic               vmem_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      page_mem[wr_idx] <= wr_entry[31:16];
      vtag_mem[wr_idx] <= wr_entry[15:0];
    end
    if (rd_en)
    begin
      page_q     <= page_mem[rd_addr.t.tidx];
      vtag_q     <= vtag_mem[rd_addr.t.tidx];
      req_page_q <= rd_addr.t.page;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
      vmem_q <= 1'b0;
    else if (rd_en)
      vmem_q <= vmem_act;
  end

  // identity mapping with translation off
  assign phys_page = vmem_q ? page_q : req_page_q;
  assign fault     = vmem_q && (vtag_q != req_page_q);

endmodule

`default_nettype wire

// ==== logic/cache_store.sv ====
`default_nettype none

`include "cache_consts.svh"

module cache_store (
  input  logic                    CPU_CLK,
  input  logic                    RST_CPU,
  input  logic                    rd_en,
  input  logic [`CACHE_IDX_W-1:0] rd_idx,
  input  logic [`CACHE_TAG_W-1:0] rd_tag,  // one cycle after rd_idx
  output logic                    hit,
  output logic [31:0]             rd_data,
  line_wr_if.target               wr
);

  logic [31:0]             data_mem [`CACHE_LINES];
  logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid;
  logic [`CACHE_TAG_W-1:0] tag_q;
  logic                    valid_q;
  logic                    fwd;

  // a line written on the same edge it is read returns the new contents
  assign fwd = wr.we && (wr.idx == rd_idx);

  always_ff @(posedge CPU_CLK)
  begin
    if (wr.we)
    begin
      data_mem[wr.idx] <= wr.data;
      tag_mem[wr.idx]  <= wr.tag;
    end
    if (rd_en)
    begin
      rd_data <= fwd ? wr.data : data_mem[rd_idx];
      tag_q   <= fwd ? wr.tag : tag_mem[rd_idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (wr.we)
        valid[wr.idx] <= 1'b1;
      if (rd_en)
        valid_q <= fwd || valid[rd_idx];
    end
  end

  assign hit = valid_q && (tag_q == rd_tag);

endmodule

`default_nettype wire

// ==== logic/cache_ifs.sv ====
`default_nettype none

`include "cache_consts.svh"

// ---------------------------------------------------------------------------
// line write from the controller into the cache arrays
// ---------------------------------------------------------------------------
interface line_wr_if;
  logic                    we;
  logic [`CACHE_IDX_W-1:0] idx;
  logic [`CACHE_TAG_W-1:0] tag;
  logic [31:0]             data;

  modport driver (output we, idx, tag, data);
  modport target (input we, idx, tag, data);
endinterface

// ---------------------------------------------------------------------------
// single word request to the wishbone master
// ---------------------------------------------------------------------------
interface bus_req_if;
  logic        req;    // one cycle, only while the port is idle
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;  // valid with done
  logic        done;

  modport requester (
    output req, we, addr, wdata,
    input  rdata, done
  );

  modport port (
    input  req, we, addr, wdata,
    output rdata, done
  );
endinterface

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

  // cache view of a word address
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;
    logic [`CACHE_IDX_W-1:0] idx;  // line select
  } cache_addr_t;

  // translation view of the same word
  typedef struct packed {
    logic [`PAGE_W-1:0]      page;  // virtual page
    logic [`CACHE_IDX_W-1:0] tidx;  // translation entry select
    logic [`CACHE_IDX_W-1:0] lidx;  // untranslated line bits
  } tlb_addr_t;

  typedef union packed {
    cache_addr_t c;
    tlb_addr_t   t;
  } cpu_addr_u;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,  // store outputs valid, decide this cycle
    BUS,     // bus cycle out, nothing parked
    FILL,    // bus cycle out, a later request parked
    DONE     // parked request looks up again
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// ---------------------------------------------------------------------------
// cache and translation buffer geometry
// ---------------------------------------------------------------------------

// one index width serves both the cache lines and the translation entries
`define CACHE_IDX_W 8
`define CACHE_LINES 256

// physical word address above the line index
`define CACHE_TAG_W 24

// virtual and physical page width
`define PAGE_W 16

`endif
